// ==== bench/memory_subsystem_tb.sv ====
/*
 * Memory subsystem testbench
 * Directed tests of fetch, load/store, bank switch and loader paths against a shadow memory
 */
`timescale 1ns/1ps
`include "mem_params.svh"

module memory_subsystem_tb;
	import mem_pkg::*;

	// Sum of the test budgets, doubled
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int BANK_BIT = `MEM_ADDRESS_BITS - 1;
	localparam int HALF = `MEM_BITS / 2;

	logic       CLK;
	logic       RSTb;
	instr_req_t instr_req;
	data_req_t  data_req;
	logic       halt;
	load_req_t  load_req;
	logic       load_valid;

	logic [`MEM_BITS-1:0]         instr_data;
	logic [`MEM_ADDRESS_BITS-1:0] instr_address_out;
	logic                         instr_success;
	logic                         instr_will_queue;
	logic [`MEM_BITS-1:0]         data_out;
	logic                         data_success;
	logic                         data_was_requested;
	logic [1:0]                   data_mask_out;
	logic                         bank_sw;
	logic                         load_ready;

	// Shadow of the whole word address space
	logic [`MEM_BITS-1:0]         shadow [(1 << `MEM_ADDRESS_BITS)];
	logic [`MEM_ADDRESS_BITS-1:0] addr0 [4];
	logic [`MEM_ADDRESS_BITS-1:0] addr1 [4];
	logic [`MEM_ADDRESS_BITS-1:0] prev_fetch;
	logic                         bank_sw_q;

	integer seed = 32'hdd09b314;
	int     checks = 0;
	int     errors = 0;
	int     cycle_count = 0;
	int     bank_sw_rises = 0;

	memory_subsystem DUT (
		.CLK(CLK), .RSTb(RSTb),
		.instr_req(instr_req), .data_req(data_req), .halt(halt),
		.instr_data(instr_data), .instr_address_out(instr_address_out),
		.instr_success(instr_success), .instr_will_queue(instr_will_queue),
		.data_out(data_out), .data_success(data_success),
		.data_was_requested(data_was_requested), .data_mask_out(data_mask_out),
		.bank_sw(bank_sw), .load_req(load_req), .load_valid(load_valid),
		.load_ready(load_ready)
	);

	always #2 CLK = ~CLK;

	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
			$display("Test FAILED");
			$finish;
		end
	end

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// No success may show while the bank is being switched
	always @(negedge CLK) begin
		if (RSTb) begin
			if (bank_sw && !bank_sw_q)
				bank_sw_rises++;
			if (bank_sw)
				check("bank switch hold", 2'b00, {instr_success, data_success});
			bank_sw_q = bank_sw;
		end
	end

	// Byte mask rule, bit 0 is the low byte
	function automatic logic [`MEM_BITS-1:0] merge_bytes(input logic [`MEM_BITS-1:0] old_word,
		input logic [`MEM_BITS-1:0] new_word, input logic [1:0] mask);
		logic [`MEM_BITS-1:0] result;
		result = old_word;
		if (mask[0])
			result[HALF-1:0] = new_word[HALF-1:0];
		if (mask[1])
			result[`MEM_BITS-1:HALF] = new_word[`MEM_BITS-1:HALF];
		return result;
	endfunction

	task automatic load_start(input logic [`MEM_ADDRESS_BITS-1:0] addr,
		input logic [`MEM_BITS-1:0] data, input logic [1:0] mask);
		load_req_t req;
		req.address = addr;
		req.data    = data;
		req.mask    = mask;
		@(posedge CLK);
		load_req   <= req;
		load_valid <= 1'b1;
	endtask

	// Write lands on the edge with valid and ready both high
	task automatic load_finish();
		logic accepted;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge CLK);
			accepted = load_ready;
		end
		@(posedge CLK);
		load_valid <= 1'b0;
		shadow[load_req.address] = merge_bytes(shadow[load_req.address], load_req.data,
			load_req.mask);
	endtask

	task automatic load_word(input logic [`MEM_ADDRESS_BITS-1:0] addr,
		input logic [`MEM_BITS-1:0] data, input logic [1:0] mask);
		load_start(addr, data, mask);
		load_finish();
	endtask

	// Request stays up on return, like a CPU moving straight to the next fetch
	task automatic fetch_check(input string name, input logic [`MEM_ADDRESS_BITS-1:0] addr);
		instr_req_t req;
		logic       done;
		req.address  = addr;
		req.read_req = 1'b1;
		done         = 1'b0;
		@(posedge CLK);
		instr_req <= req;
		while (!done) begin
			@(negedge CLK);
			if (instr_success) begin
				// Repeats of the previous fetch may still drain out
				if (instr_address_out === addr)
					done = 1'b1;
				else if (instr_address_out !== prev_fetch)
					check(name, addr, instr_address_out);
			end
		end
		check(name, shadow[addr], instr_data);
		prev_fetch = addr;
	endtask

	// Drop all requests and let both stages empty
	task automatic release_cpu();
		@(posedge CLK);
		instr_req <= '0;
		data_req  <= '0;
		repeat (3) @(posedge CLK);
	endtask

	task automatic data_access(input string name, input logic [`MEM_ADDRESS_BITS-1:0] addr,
		input logic [`MEM_BITS-1:0] wdata, input logic write, input logic [1:0] mask,
		output logic [`MEM_BITS-1:0] rdata);
		data_req_t req;
		logic      done;
		req.address   = addr;
		req.wdata     = wdata;
		req.read_req  = !write;
		req.write_req = write;
		req.mask      = mask;
		done          = 1'b0;
		@(posedge CLK);
		data_req <= req;
		while (!done) begin
			@(negedge CLK);
			if (data_was_requested)
				check(name, mask, data_mask_out);
			done = data_success;
		end
		rdata = data_out;
		if (write)
			shadow[addr] = merge_bytes(shadow[addr], wdata, mask);
		release_cpu();
	endtask

	task automatic reset_test();
		@(negedge CLK);
		check("reset valid", 1'b0, DUT.valid);
		check("reset bank_sw", 1'b0, bank_sw);
		check("reset success", 2'b00, {instr_success, data_success});
		check("reset data_was_requested", 1'b0, data_was_requested);
		check("reset instr_will_queue", 1'b0, instr_will_queue);
		check("reset load_ready", 1'b1, load_ready);
	endtask

	task automatic loader_fetch_test();
		logic [`MEM_BITS-1:0] value;
		for (int i = 0; i < 4; i++) begin
			addr0[i] = $random(seed);
			addr0[i][BANK_BIT] = 1'b0;
			addr1[i] = $random(seed);
			addr1[i][BANK_BIT] = 1'b1;
			value = $random(seed);
			load_word(addr0[i], value, 2'b11);
			value = $random(seed);
			load_word(addr1[i], value, 2'b11);
		end
		// Back to back fetches, all in bank 0
		for (int i = 0; i < 4; i++)
			fetch_check("loader fetch", addr0[i]);
		release_cpu();
	endtask

	task automatic masked_store_test();
		logic [`MEM_BITS-1:0] wdata;
		logic [`MEM_BITS-1:0] rdata;
		wdata = $random(seed);
		data_access("store low mask", addr0[0], wdata, 1'b1, 2'b01, rdata);
		data_access("load low mask", addr0[0], '0, 1'b0, 2'b11, rdata);
		check("masked store low", shadow[addr0[0]], rdata);
		wdata = $random(seed);
		data_access("store high mask", addr0[1], wdata, 1'b1, 2'b10, rdata);
		data_access("load high mask", addr0[1], '0, 1'b0, 2'b11, rdata);
		check("masked store high", shadow[addr0[1]], rdata);
	endtask

	task automatic priority_test();
		instr_req_t ireq;
		data_req_t  dreq;
		logic       data_done;
		logic       instr_done;
		logic       queued;
		ireq.address  = addr0[2];
		ireq.read_req = 1'b1;
		dreq          = '0;
		dreq.address  = addr0[3];
		dreq.read_req = 1'b1;
		dreq.mask     = 2'b11;
		data_done     = 1'b0;
		instr_done    = 1'b0;
		queued        = 1'b0;
		@(posedge CLK);
		instr_req <= ireq;
		data_req  <= dreq;
		while (!(data_done && instr_done)) begin
			@(negedge CLK);
			// Fetch must not be taken while a data request is up
			if (data_req.read_req)
				check("priority queue blocked", 1'b0, instr_will_queue);
			else if (instr_will_queue)
				queued = 1'b1;
			if (data_success && !data_done) begin
				data_done = 1'b1;
				check("priority data", shadow[addr0[3]], data_out);
			end
			if (instr_success && !instr_done && instr_address_out === addr0[2]) begin
				instr_done = 1'b1;
				check("priority order", 1'b1, data_done);
				check("priority fetch", shadow[addr0[2]], instr_data);
			end
			@(posedge CLK);
			if (data_done)
				data_req <= '0;
		end
		check("priority fetch queued", 1'b1, queued);
		prev_fetch = addr0[2];
		release_cpu();
	endtask

	task automatic bank_switch_test();
		int rises;
		rises = bank_sw_rises;
		fetch_check("bank switch bank 0", addr0[0]);
		fetch_check("bank switch bank 1", addr1[0]);
		check("bank switch pulse", 1, bank_sw_rises - rises);
		release_cpu();
	endtask

	task automatic loader_exclusion_test();
		logic [`MEM_BITS-1:0] value;
		value = $random(seed);
		// CPU side still holds the memory from the last test
		load_start(addr1[1], value, 2'b11);
		repeat (8) begin
			@(negedge CLK);
			check("exclusion load_ready", 1'b0, load_ready);
		end
		@(posedge CLK);
		halt <= 1'b1;
		repeat (2) @(negedge CLK);
		check("exclusion valid", 1'b0, DUT.valid);
		load_finish();
		halt <= 1'b0;
		fetch_check("exclusion fetch", addr1[1]);
		release_cpu();
	endtask

	initial begin
		CLK        = 1'b0;
		RSTb       = 1'b0;
		instr_req  = '0;
		data_req   = '0;
		halt       = 1'b0;
		load_req   = '0;
		load_valid = 1'b0;
		bank_sw_q  = 1'b0;
		prev_fetch = '1;
		repeat (10) @(posedge CLK);
		RSTb <= 1'b1;

		reset_test();
		loader_fetch_test();
		masked_store_test();
		priority_test();
		bank_switch_test();
		loader_exclusion_test();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== logic/bank_arbiter.sv ====
/*
 * Bank arbiter
 * Lends the banks to the CPU interface or the loader, returns read data
 */
`timescale 1ns/1ps
`include "mem_params.svh"

module bank_arbiter (
	input  logic                         CLK,
	input  logic                         RSTb,
	input  logic                         valid,
	input  mem_pkg::mem_port_t           mem_port,
	input  logic                         mem_wr,
	output logic                         rdy,
	output logic [`MEM_BITS-1:0]         mem_rdata,
	input  mem_pkg::load_req_t           load_req,
	input  logic                         load_valid,
	output logic                         load_ready,
	output logic [`MEM_ADDRESS_BITS-2:0] bank_address,
	output logic [`MEM_BITS-1:0]         bank_wdata,
	output logic [1:0]                   bank_mask,
	output logic [1:0]                   bank_enable,
	output logic                         bank_write,
	input  logic [`MEM_BITS-1:0]         bank0_rdata,
	input  logic [`MEM_BITS-1:0]         bank1_rdata
);
	import mem_pkg::*;

	localparam int BANK_BIT = `MEM_ADDRESS_BITS - 1;

	logic      owner_cpu;
	logic      load_staged;
	logic      load_write;
	logic      bus_active;
	logic      bank_sel_q;
	mem_port_t bank_bus;

	// Loader gets the banks only while the CPU side is out
	// Its access must sit in the bank registers one cycle before the strobe
	assign load_ready = !valid && !owner_cpu && (!load_valid || load_staged);
	assign load_write = load_valid && load_ready;

	assign rdy = owner_cpu;

	always_comb begin
		if (owner_cpu)
			bank_bus = mem_port;
		else
			bank_bus = '{address: {1'b0, load_req.address}, wdata: load_req.data,
				mask: load_req.mask};
	end

	assign bus_active   = owner_cpu || load_valid;
	assign bank_address = bank_bus.address[BANK_BIT-1:0];
	assign bank_wdata   = bank_bus.wdata;
	assign bank_mask    = bank_bus.mask;
	// One-hot bank select from the bank bit
	assign bank_enable  = bus_active ? (bank_bus.address[BANK_BIT] ? 2'b10 : 2'b01) : 2'b00;

	// Loader strobe goes straight out
	assign bank_write = owner_cpu ? mem_wr : load_write;

	// Read data follows the bank addressed last cycle
	assign mem_rdata = bank_sel_q ? bank1_rdata : bank0_rdata;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			owner_cpu   <= 1'b0;
			load_staged <= 1'b0;
		end else begin
			owner_cpu   <= valid && !load_write;
			// Loader word captured by the banks at this edge
			load_staged <= load_valid && !valid && !owner_cpu && !load_write;
		end
	end

	always_ff @(posedge CLK) begin
		bank_sel_q <= bank_bus.address[BANK_BIT];
	end

endmodule

// ==== logic/cpu_memory_interface.sv ====
/*
 * CPU memory interface
 * Two-stage arbiter between fetch and load/store paths with bank-switch control
 */
`timescale 1ns/1ps
`include "mem_params.svh"

module cpu_memory_interface (
	input  logic                         CLK,
	input  logic                         RSTb,
	input  mem_pkg::instr_req_t          instr_req,
	input  mem_pkg::data_req_t           data_req,
	input  logic                         halt,
	output logic [`MEM_BITS-1:0]         instr_data,
	output logic [`MEM_ADDRESS_BITS-1:0] instr_address_out,
	output logic                         instr_success,
	output logic                         instr_will_queue,
	output logic [`MEM_BITS-1:0]         data_out,
	output logic                         data_success,
	output logic                         data_was_requested,
	output logic [1:0]                   data_mask_out,
	output logic                         bank_sw,
	output mem_pkg::mem_port_t           mem_port,
	output logic                         mem_wr,
	output logic                         valid,
	input  logic [`MEM_BITS-1:0]         mem_rdata,
	input  logic                         rdy
);
	import mem_pkg::*;

	// Word address bit that selects the bank
	localparam int BANK_BIT = `MEM_ADDRESS_BITS - 1;

	arb_state_t state, state_next;

	// Stage 1 is on the bus, stage 2 sees the result
	logic [`MEM_ADDRESS_BITS-1:0] address_s1, address_s1_next, address_s2;
	logic [`MEM_BITS-1:0]         data_s1, data_s1_next, data_s2;
	mem_flags_t                   flags_s1, flags_s1_next, flags_s2;
	logic [1:0]                   mask_s1, mask_s1_next, mask_s2;

	logic bank_switch_required;
	logic bank_switch_next;
	logic data_request;
	logic stage2_live;

	assign data_request = data_req.read_req || data_req.write_req;

	// Both stages live and on opposite banks
	assign bank_switch_next = flags_s1.requested && flags_s2.requested &&
		(address_s1[BANK_BIT] != address_s2[BANK_BIT]);

	always_comb begin
		state_next       = state;
		address_s1_next  = address_s1;
		data_s1_next     = data_s1;
		flags_s1_next    = flags_s1;
		mask_s1_next     = mask_s1;
		instr_will_queue = 1'b0;

		case (state)
			st_idle: begin
				flags_s1_next = '0;
				if (data_request || instr_req.read_req)
					state_next = st_request_bank;
			end
			st_request_bank: begin
				// Reloaded request moves on to stage 2 as the grant lands
				if (rdy) begin
					state_next              = st_execute;
					flags_s1_next.requested = 1'b0;
				end
			end
			st_execute: begin
				if (bank_switch_required) begin
					// Replay stage 2 once the memory is regained
					state_next      = st_bank_switch;
					address_s1_next = address_s2;
					data_s1_next    = data_s2;
					mask_s1_next    = mask_s2;
					flags_s1_next.read  = 1'b1;
					flags_s1_next.instr = flags_s2.instr;
					// Writes come back through the CPU retry
					flags_s1_next.requested = flags_s2.requested && flags_s2.read;
				end else if (data_request) begin
					// Data side wins over fetch
					address_s1_next = data_req.address;
					data_s1_next    = data_req.wdata;
					mask_s1_next    = data_req.mask;
					flags_s1_next.read      = data_req.read_req;
					flags_s1_next.instr     = 1'b0;
					flags_s1_next.requested = 1'b1;
				end else if (instr_req.read_req) begin
					address_s1_next = instr_req.address;
					mask_s1_next    = 2'b00;
					flags_s1_next.read      = 1'b1;
					flags_s1_next.instr     = 1'b1;
					flags_s1_next.requested = 1'b1;
					instr_will_queue        = 1'b1;
				end else begin
					flags_s1_next = '0;
					// Let go of the memory
					if (halt)
						state_next = st_idle;
				end
			end
			st_bank_switch: begin
				// One cycle with the grant released
				state_next = st_request_bank;
			end
			default: begin
				state_next = st_idle;
			end
		endcase
	end

	// Control state
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state                <= st_idle;
			flags_s1             <= '0;
			flags_s2             <= '0;
			bank_switch_required <= 1'b0;
		end else begin
			state                <= state_next;
			flags_s1             <= flags_s1_next;
			flags_s2             <= flags_s1;
			bank_switch_required <= bank_switch_next;
		end
	end

	// Payload, pipeline always advances
	always_ff @(posedge CLK) begin
		address_s1 <= address_s1_next;
		data_s1    <= data_s1_next;
		mask_s1    <= mask_s1_next;
		address_s2 <= address_s1;
		data_s2    <= data_s1;
		mask_s2    <= mask_s1;
	end

	assign mem_port = '{address: {1'b0, address_s1}, wdata: data_s1, mask: mask_s1};

	// Read data straight from the banks
	assign instr_data = mem_rdata;
	assign data_out   = mem_rdata;

	// Stage 2 result counts only with the grant held and no switch pending
	assign stage2_live = flags_s2.requested && !bank_switch_required &&
		(state == st_execute);

	assign instr_success      = stage2_live && flags_s2.instr;
	assign data_success       = stage2_live && !flags_s2.instr;
	assign mem_wr             = stage2_live && !flags_s2.instr && !flags_s2.read;
	assign data_was_requested = flags_s2.requested && !flags_s2.instr;
	assign instr_address_out  = address_s2;
	assign data_mask_out      = mask_s2;

	assign valid   = (state == st_request_bank) || (state == st_execute);
	assign bank_sw = (state == st_bank_switch) || (state == st_request_bank);

endmodule

// ==== logic/mem_params.svh ====
/*
 * Memory subsystem parameters
 * Word width, word address width and the depth of one bank
 */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Data word width
`define MEM_BITS 16

// Word address width, top bit picks the bank
`define MEM_ADDRESS_BITS 15

// Words per bank, half the word address space
`define MEM_BANK_WORDS (1 << (`MEM_ADDRESS_BITS - 1))

`endif

// ==== logic/mem_pkg.sv ====
/*
 * Memory subsystem types
 * Request buses, memory port, pipeline flags and arbiter states
 */
`include "mem_params.svh"

package mem_pkg;

	// Instruction fetch request
	typedef struct packed {
		logic [`MEM_ADDRESS_BITS-1:0] address;
		logic                         read_req;
	} instr_req_t;

	// Data load/store request, mask bit 0 is the low byte
	typedef struct packed {
		logic [`MEM_ADDRESS_BITS-1:0] address;
		logic [`MEM_BITS-1:0]         wdata;
		logic                         read_req;
		logic                         write_req;
		logic [1:0]                   mask;
	} data_req_t;

	// Memory side bus, one extra address bit tied low
	typedef struct packed {
		logic [`MEM_ADDRESS_BITS:0] address;
		logic [`MEM_BITS-1:0]       wdata;
		logic [1:0]                 mask;
	} mem_port_t;

	// External loader write
	typedef struct packed {
		logic [`MEM_ADDRESS_BITS-1:0] address;
		logic [`MEM_BITS-1:0]         data;
		logic [1:0]                   mask;
	} load_req_t;

	// Pipeline stage flags
	typedef struct packed {
		logic read;      // 1 = read, 0 = write
		logic instr;     // 1 = fetch, 0 = data
		logic requested;
	} mem_flags_t;

	typedef enum logic [1:0] {
		st_idle         = 2'd0,
		st_request_bank = 2'd1,
		st_execute      = 2'd2,
		st_bank_switch  = 2'd3
	} arb_state_t;

endpackage

// ==== logic/memory_bank.sv ====
/*
 * Memory bank
 * Synchronous RAM with byte write mask and registered access
 */
`timescale 1ns/1ps
`include "mem_params.svh"

module memory_bank (
	input  logic                         CLK,
	input  logic                         enable,
	input  logic [`MEM_ADDRESS_BITS-2:0] address,
	input  logic [`MEM_BITS-1:0]         wdata,
	input  logic [1:0]                   mask,
	input  logic                         write,
	output logic [`MEM_BITS-1:0]         rdata
);
	// Byte boundary inside a word
	localparam int HALF = `MEM_BITS / 2;

	logic [`MEM_BITS-1:0] mem [`MEM_BANK_WORDS];

	logic [`MEM_ADDRESS_BITS-2:0] address_q;
	logic [`MEM_BITS-1:0]         wdata_q;
	logic [1:0]                   mask_q;
	logic                         enable_q;

	// Capture whatever is presented
	always_ff @(posedge CLK) begin
		address_q <= address;
		wdata_q   <= wdata;
		mask_q    <= mask;
		enable_q  <= enable;
	end

	// Strobe commits last cycle's access
	always_ff @(posedge CLK) begin
		if (write && enable_q) begin
			if (mask_q[0])
				mem[address_q][HALF-1:0] <= wdata_q[HALF-1:0];
			if (mask_q[1])
				mem[address_q][`MEM_BITS-1:HALF] <= wdata_q[`MEM_BITS-1:HALF];
		end
	end

	assign rdata = mem[address_q];

endmodule

// ==== logic/memory_subsystem.sv ====
/*
 * Memory subsystem top level
 * CPU memory interface, bank arbiter and two RAM banks
 */
`timescale 1ns/1ps
`include "mem_params.svh"

module memory_subsystem (
	input  logic                         CLK,
	input  logic                         RSTb,
	input  mem_pkg::instr_req_t          instr_req,
	input  mem_pkg::data_req_t           data_req,
	input  logic                         halt,
	output logic [`MEM_BITS-1:0]         instr_data,
	output logic [`MEM_ADDRESS_BITS-1:0] instr_address_out,
	output logic                         instr_success,
	output logic                         instr_will_queue,
	output logic [`MEM_BITS-1:0]         data_out,
	output logic                         data_success,
	output logic                         data_was_requested,
	output logic [1:0]                   data_mask_out,
	output logic                         bank_sw,
	input  mem_pkg::load_req_t           load_req,
	input  logic                         load_valid,
	output logic                         load_ready
);
	import mem_pkg::*;

	// Interface to arbiter
	mem_port_t            mem_port;
	logic                 mem_wr;
	logic                 valid;
	logic                 rdy;
	logic [`MEM_BITS-1:0] mem_rdata;

	// Arbiter to banks
	logic [`MEM_ADDRESS_BITS-2:0] bank_address;
	logic [`MEM_BITS-1:0]         bank_wdata;
	logic [1:0]                   bank_mask;
	logic [1:0]                   bank_enable;
	logic                         bank_write;
	logic [`MEM_BITS-1:0]         bank0_rdata;
	logic [`MEM_BITS-1:0]         bank1_rdata;

	cpu_memory_interface u_cpu_if (
		.CLK(CLK), .RSTb(RSTb),
		.instr_req(instr_req), .data_req(data_req), .halt(halt),
		.instr_data(instr_data), .instr_address_out(instr_address_out),
		.instr_success(instr_success), .instr_will_queue(instr_will_queue),
		.data_out(data_out), .data_success(data_success),
		.data_was_requested(data_was_requested), .data_mask_out(data_mask_out),
		.bank_sw(bank_sw), .mem_port(mem_port), .mem_wr(mem_wr), .valid(valid),
		.mem_rdata(mem_rdata), .rdy(rdy)
	);

	bank_arbiter u_arbiter (
		.CLK(CLK), .RSTb(RSTb),
		.valid(valid), .mem_port(mem_port), .mem_wr(mem_wr), .rdy(rdy), .mem_rdata(mem_rdata),
		.load_req(load_req), .load_valid(load_valid), .load_ready(load_ready),
		.bank_address(bank_address), .bank_wdata(bank_wdata), .bank_mask(bank_mask),
		.bank_enable(bank_enable), .bank_write(bank_write),
		.bank0_rdata(bank0_rdata), .bank1_rdata(bank1_rdata)
	);

	// Lower half of the word address space
	memory_bank bank0 (
		.CLK(CLK), .enable(bank_enable[0]), .address(bank_address), .wdata(bank_wdata),
		.mask(bank_mask), .write(bank_write), .rdata(bank0_rdata)
	);

	// Upper half
	memory_bank bank1 (
		.CLK(CLK), .enable(bank_enable[1]), .address(bank_address), .wdata(bank_wdata),
		.mask(bank_mask), .write(bank_write), .rdata(bank1_rdata)
	);

endmodule

// ==== vlog.f ====
+incdir+logic
logic/mem_pkg.sv
logic/memory_bank.sv
logic/bank_arbiter.sv
logic/cpu_memory_interface.sv
logic/memory_subsystem.sv
bench/memory_subsystem_tb.sv
